//--- Makefile
# Verilator build and run of the execute pipeline testbench

VERILATOR ?= verilator
TOP ?= tb_exec_pipe
SEED_ARGS ?=
BUILD_DIR ?= build
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f flist.f
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(BUILD_DIR)

//--- common/exec_pkg.sv
package exec_pkg;

    localparam int xlen = 32;
    localparam int reg_idx_w = 5;

    // bit 4 selects the immediate as operand b, bits 3..0 the operation
    localparam int uop_w = 5;
    localparam int uop_imm_bit = 4;

    // exception code, top bit marks a valid code
    localparam int excp_code_w = 7;
    localparam int excp_valid_bit = 6;

    localparam logic [xlen-1:0] inst_nop = 32'h0340_0000;

    // flat EX1/EX2 bundle without the two inst fields
    // 12 words, 2 uops, 6 register indices, exception code, 5 flag bits
    localparam int ex1_ex2_bundle_w = 12 * xlen + 2 * uop_w + 6 * reg_idx_w
                                      + excp_code_w + 5;

    typedef enum logic [3:0] {
        op_add     = 4'd0,
        op_sub     = 4'd1,
        op_and     = 4'd2,
        op_or      = 4'd3,
        op_xor     = 4'd4,
        op_sll     = 4'd5,
        op_srl     = 4'd6,
        op_sra     = 4'd7,
        op_slt     = 4'd8,
        op_sltu    = 4'd9,
        op_mul_w   = 4'd10,
        op_mulh_w  = 4'd11,
        op_mulh_wu = 4'd12
    } uop_op_e;

    function automatic logic is_mul_op(input uop_op_e op);
        return op inside {op_mul_w, op_mulh_w, op_mulh_wu};
    endfunction

endpackage

//--- ex1_stage/ex1_alu.sv
`timescale 1ns/10ps

module ex1_alu (
    input  logic [exec_pkg::uop_w-1:0] uop,
    input  logic [exec_pkg::xlen-1:0]  src_a,
    input  logic [exec_pkg::xlen-1:0]  src_b,
    input  logic [exec_pkg::xlen-1:0]  imm,
    output logic [exec_pkg::xlen-1:0]  result,
    output logic                       result_valid
);
    import exec_pkg::*;

    uop_op_e         op;
    logic [xlen-1:0] opnd_b;
    logic [4:0]      shamt;

    assign op = uop_op_e'(uop[3:0]);

    // immediate forms replace the second register operand
    assign opnd_b = uop[uop_imm_bit] ? imm : src_b;
    assign shamt = opnd_b[4:0];

    always_comb begin
        result_valid = 1'b1;
        case (op)
            op_add:  result = src_a + opnd_b;
            op_sub:  result = src_a - opnd_b;
            op_and:  result = src_a & opnd_b;
            op_or:   result = src_a | opnd_b;
            op_xor:  result = src_a ^ opnd_b;
            op_sll:  result = src_a << shamt;
            op_srl:  result = src_a >> shamt;
            op_sra:  result = $signed(src_a) >>> shamt;
            op_slt:  result = xlen'($signed(src_a) < $signed(opnd_b));
            op_sltu: result = xlen'(src_a < opnd_b);
            default: begin
                // multiplies finish in EX2, unused codes are never valid
                result = src_a + opnd_b;
                result_valid = 1'b0;
            end
        endcase
    end

endmodule

//--- ex1_stage/ex1_mul_partial.sv
`timescale 1ns/10ps

module ex1_mul_partial (
    input  logic [exec_pkg::xlen-1:0] src_a,
    input  logic [exec_pkg::xlen-1:0] src_b,
    output logic [exec_pkg::xlen-1:0] res_hh,
    output logic [exec_pkg::xlen-1:0] res_hl,
    output logic [exec_pkg::xlen-1:0] res_lh,
    output logic [exec_pkg::xlen-1:0] res_ll,
    output logic [exec_pkg::xlen-1:0] compensate
);
    import exec_pkg::*;

    localparam int half = xlen / 2;

    logic [half-1:0] a_hi;
    logic [half-1:0] a_lo;
    logic [half-1:0] b_hi;
    logic [half-1:0] b_lo;

    assign a_hi = src_a[xlen-1:half];
    assign a_lo = src_a[half-1:0];
    assign b_hi = src_b[xlen-1:half];
    assign b_lo = src_b[half-1:0];

    // unsigned 16x16 products, first letter is the half of a
    assign res_hh = a_hi * b_hi;
    assign res_hl = a_hi * b_lo;
    assign res_lh = a_lo * b_hi;
    assign res_ll = a_lo * b_lo;

    // signed high word = unsigned high word minus this
    assign compensate = (src_a[xlen-1] ? src_b : '0) + (src_b[xlen-1] ? src_a : '0);

endmodule

//--- flist.f
common/exec_pkg.sv
ex1_stage/ex1_alu.sv
ex1_stage/ex1_mul_partial.sv
verilog/ex1_ex2_reg.sv
verilog/ex2_mul_merge.sv
verilog/exec_pipe_top.sv
sim/exec_pipe_asserts.sv
sim/tb_exec_pipe.sv

//--- sim/exec_pipe_asserts.sv
`timescale 1ns/10ps

module exec_pipe_asserts (
    input logic                                  clk,
    input logic                                  arst_n,
    input logic                                  flush_in,
    input logic                                  ex1_readygo,
    input logic                                  ex2_allowin,
    input logic [exec_pkg::ex1_ex2_bundle_w-1:0] bundle_q,
    input logic [exec_pkg::xlen-1:0]             inst0,
    input logic [exec_pkg::xlen-1:0]             inst1,
    input logic                                  valid0,
    input logic                                  valid1,
    input logic                                  excp_flag
);
    import exec_pkg::*;

    // assertion failures so far
    int unsigned fail_count = 0;

    // an empty EX1 slot turns into a bubble
    bubble_on_idle: assert property (@(posedge clk) disable iff (!arst_n)
        (ex2_allowin && !ex1_readygo)
        |=> (!valid0 && !valid1 && !excp_flag && inst0 == inst_nop))
        else begin
            $error("no bubble after an empty EX1 slot");
            fail_count++;
        end

    // back-pressure freezes the whole bundle
    hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (!ex2_allowin && !flush_in) |=> ($stable(bundle_q) && $stable(inst0) && $stable(inst1)))
        else begin
            $error("register changed while held");
            fail_count++;
        end

    flush_clears: assert property (@(posedge clk) disable iff (!arst_n)
        flush_in |=> (!valid0 && !valid1 && !excp_flag && inst0 == inst_nop))
        else begin
            $error("register not cleared after flush");
            fail_count++;
        end

endmodule

bind ex1_ex2_reg exec_pipe_asserts exec_pipe_asserts_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .flush_in    (flush_in),
    .ex1_readygo (ex1_readygo),
    .ex2_allowin (ex2_allowin),
    .bundle_q    (bundle_q),
    .inst0       (ex1_ex2_inst0),
    .inst1       (ex1_ex2_inst1),
    .valid0      (ex1_ex2_alu_result0_valid),
    .valid1      (ex1_ex2_alu_result1_valid),
    .excp_flag   (ex1_ex2_excp_flag)
);

//--- sim/tb_exec_pipe.sv
`timescale 1ns/10ps

module tb_exec_pipe;
    import exec_pkg::*;

    localparam int num_cycles = 3000;
    localparam int reset_cycles = 10;
    localparam int reset_timeout = 50;

    logic clk;
    logic arst_n;
    logic flush_in, ex1_readygo, ex2_allowin, ex1_allowin;
    logic [xlen-1:0] ex1_pc0, ex1_pc1, ex1_inst0, ex1_inst1, ex1_imm0, ex1_imm1;
    logic [uop_w-1:0] ex1_uop0, ex1_uop1;
    logic [reg_idx_w-1:0] ex1_rj0, ex1_rj1, ex1_rk0, ex1_rk1, ex1_rd0, ex1_rd1;
    logic [xlen-1:0] src_a0, src_b0, src_a1, src_b1;
    logic privileged_0, csr_ren, excp_flag_in;
    logic [excp_code_w-1:0] exception_in, d_exception;
    logic [xlen-1:0] badv_in, d_badv;

    logic [xlen-1:0] pc0, pc1, inst0, inst1, imm0, imm1, res0, res1, badv;
    logic [reg_idx_w-1:0] rd0, rd1, rj0, rj1, rk0, rk1;
    logic res0_valid, res1_valid, privileged, csr_ren_ex2, excp_flag;
    logic [excp_code_w-1:0] exception;

    // expected EX2 state
    logic [xlen-1:0] exp_pc0, exp_pc1, exp_inst0, exp_inst1, exp_imm0, exp_imm1;
    logic [xlen-1:0] exp_res0, exp_res1, exp_badv;
    logic [reg_idx_w-1:0] exp_rd0, exp_rd1, exp_rj0, exp_rj1, exp_rk0, exp_rk1;
    logic exp_res0_valid, exp_res1_valid, exp_priv, exp_csr_ren, exp_excp_flag;
    logic [excp_code_w-1:0] exp_exception;

    exec_pipe_top exec_pipe_top_inst (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1 arst_n = 1'b1;
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s actual=%h expected=%h", name, actual, expected);
            $display("test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // reference ALU in 64-bit arithmetic
    function automatic logic [xlen-1:0] alu_model(input logic [uop_w-1:0] uop,
            input logic [xlen-1:0] a, input logic [xlen-1:0] b, input logic [xlen-1:0] imm);
        logic [xlen-1:0] ob;
        longint sa;
        longint sb;
        int unsigned sh;
        ob = uop[uop_imm_bit] ? imm : b;
        sa = longint'($signed(a));
        sb = longint'($signed(ob));
        sh = ob % 32;
        case (uop_op_e'(uop[3:0]))
            op_add:  return a + ob;
            op_sub:  return a + ~ob + 1;
            op_and:  return a & ob;
            op_or:   return a | ob;
            op_xor:  return a ^ ob;
            op_sll:  return xlen'(64'(a) << sh);
            op_srl:  return a >> sh;
            op_sra:  return xlen'(sa >>> sh);
            op_slt:  return (sa < sb) ? 1 : 0;
            op_sltu: return (a < ob) ? 1 : 0;
            default: return a + ob;
        endcase
    endfunction

    function automatic logic [xlen-1:0] mul_model(input logic [3:0] op,
            input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        longint unsigned pu;
        longint ps;
        pu = {32'b0, a} * {32'b0, b};
        ps = longint'($signed(a)) * longint'($signed(b));
        if (uop_op_e'(op) == op_mul_w)
            return pu[31:0];
        else if (uop_op_e'(op) == op_mulh_wu)
            return pu[63:32];
        return ps[63:32];
    endfunction

    function automatic logic [xlen-1:0] pick_operand();
        logic [xlen-1:0] corners [4];
        corners = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        if ($urandom_range(3) == 0)
            return corners[$urandom_range(3)];
        return $urandom;
    endfunction

    task automatic clear_model();
        {exp_pc0, exp_pc1, exp_imm0, exp_imm1, exp_res0, exp_res1, exp_badv} = '0;
        {exp_rd0, exp_rd1, exp_rj0, exp_rj1, exp_rk0, exp_rk1} = '0;
        {exp_res0_valid, exp_res1_valid, exp_priv, exp_csr_ren, exp_excp_flag} = '0;
        exp_exception = '0;
        exp_inst0 = inst_nop;
        exp_inst1 = inst_nop;
    endtask

    task automatic accept_model();
        {exp_pc0, exp_pc1, exp_inst0, exp_inst1} = {ex1_pc0, ex1_pc1, ex1_inst0, ex1_inst1};
        {exp_imm0, exp_imm1} = {ex1_imm0, ex1_imm1};
        {exp_rd0, exp_rd1, exp_rj0, exp_rj1} = {ex1_rd0, ex1_rd1, ex1_rj0, ex1_rj1};
        {exp_rk0, exp_rk1} = {ex1_rk0, ex1_rk1};
        exp_priv = privileged_0;
        exp_csr_ren = csr_ren;
        // earlier exception wins over the decode one
        exp_excp_flag = excp_flag_in | d_exception[excp_code_w-1];
        exp_exception = excp_flag_in ? exception_in : d_exception;
        exp_badv = excp_flag_in ? badv_in : d_badv;
        if (ex1_uop0[3:0] inside {op_mul_w, op_mulh_w, op_mulh_wu}) begin
            exp_res0 = mul_model(ex1_uop0[3:0], src_a0, src_b0);
            exp_res0_valid = 1'b1;
        end else begin
            exp_res0 = alu_model(ex1_uop0, src_a0, src_b0, ex1_imm0);
            exp_res0_valid = ex1_uop0[3:0] <= 4'(op_sltu);
        end
        exp_res1 = alu_model(ex1_uop1, src_a1, src_b1, ex1_imm1);
        exp_res1_valid = ex1_uop1[3:0] <= 4'(op_sltu);
    endtask

    task automatic update_model();
        if (flush_in || (ex2_allowin && !ex1_readygo))
            clear_model();
        else if (ex2_allowin)
            accept_model();
    endtask

    task automatic drive_inputs();
        ex1_readygo = $urandom_range(99) < 70;
        ex2_allowin = $urandom_range(99) < 75;
        flush_in = $urandom_range(99) < 5;
        {ex1_pc0, ex1_pc1, ex1_inst0, ex1_inst1} = {$urandom, $urandom, $urandom, $urandom};
        {ex1_imm0, ex1_imm1} = {$urandom, $urandom};
        ex1_uop0 = uop_w'($urandom);
        ex1_uop1 = uop_w'($urandom);
        // lean lane 0 toward the multiplier
        if ($urandom_range(9) < 3)
            ex1_uop0[3:0] = 4'(10 + $urandom_range(2));
        {ex1_rj0, ex1_rj1, ex1_rk0} = 15'($urandom);
        {ex1_rk1, ex1_rd0, ex1_rd1} = 15'($urandom);
        src_a0 = pick_operand();
        src_b0 = pick_operand();
        src_a1 = pick_operand();
        src_b1 = pick_operand();
        {privileged_0, csr_ren} = 2'($urandom);
        excp_flag_in = $urandom_range(99) < 20;
        exception_in = excp_code_w'($urandom);
        d_exception = excp_code_w'($urandom);
        {badv_in, d_badv} = {$urandom, $urandom};
    endtask

    task automatic check_outputs();
        check_value("ex1_allowin", ex1_allowin, ex2_allowin);
        check_value("pc0", pc0, exp_pc0);
        check_value("pc1", pc1, exp_pc1);
        check_value("inst0", inst0, exp_inst0);
        check_value("inst1", inst1, exp_inst1);
        check_value("rd0", rd0, exp_rd0);
        check_value("rd1", rd1, exp_rd1);
        check_value("rj0", rj0, exp_rj0);
        check_value("rj1", rj1, exp_rj1);
        check_value("rk0", rk0, exp_rk0);
        check_value("rk1", rk1, exp_rk1);
        check_value("imm0", imm0, exp_imm0);
        check_value("imm1", imm1, exp_imm1);
        check_value("res0", res0, exp_res0);
        check_value("res0_valid", res0_valid, exp_res0_valid);
        check_value("res1", res1, exp_res1);
        check_value("res1_valid", res1_valid, exp_res1_valid);
        check_value("privileged", privileged, exp_priv);
        check_value("csr_ren_ex2", csr_ren_ex2, exp_csr_ren);
        check_value("excp_flag", excp_flag, exp_excp_flag);
        check_value("exception", exception, exp_exception);
        check_value("badv", badv, exp_badv);
    endtask

    initial begin
        int wait_cycles;
        void'($urandom(32'h25e3));
        drive_inputs();
        // hold the register during reset
        ex2_allowin = 1'b0;
        flush_in = 1'b0;
        clear_model();
        wait_cycles = 0;
        while (arst_n !== 1'b1) begin
            if (wait_cycles >= reset_timeout) begin
                $display("reset was not released within %0d cycles", reset_timeout);
                $display("test failed");
                $fatal(1, "reset timeout");
            end
            @(posedge clk);
            #3;
            wait_cycles++;
        end
        check_outputs();
        for (int cyc = 0; cyc < num_cycles; cyc++) begin
            @(posedge clk);
            update_model();
            #1;
            check_outputs();
            drive_inputs();
        end
        if (exec_pipe_top_inst.ex1_ex2_reg_inst.exec_pipe_asserts_inst.fail_count != 0) begin
            $display("assertions on the EX1/EX2 register failed during the run");
            $display("test failed");
            $fatal(1, "assertion failures");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

//--- verilog/ex1_ex2_reg.sv
`timescale 1ns/10ps

module ex1_ex2_reg (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                flush_in,
    input  logic                                ex1_readygo,
    input  logic                                ex2_allowin,
    output logic                                ex1_allowin,

    input  logic [exec_pkg::xlen-1:0]           pc0,
    input  logic [exec_pkg::xlen-1:0]           pc1,
    input  logic [exec_pkg::xlen-1:0]           inst0,
    input  logic [exec_pkg::xlen-1:0]           inst1,
    input  logic [exec_pkg::uop_w-1:0]          uop0,
    input  logic [exec_pkg::uop_w-1:0]          uop1,
    input  logic [exec_pkg::xlen-1:0]           imm0,
    input  logic [exec_pkg::xlen-1:0]           imm1,
    input  logic [exec_pkg::reg_idx_w-1:0]      rj0,
    input  logic [exec_pkg::reg_idx_w-1:0]      rj1,
    input  logic [exec_pkg::reg_idx_w-1:0]      rk0,
    input  logic [exec_pkg::reg_idx_w-1:0]      rk1,
    input  logic [exec_pkg::reg_idx_w-1:0]      rd0,
    input  logic [exec_pkg::reg_idx_w-1:0]      rd1,
    input  logic [exec_pkg::xlen-1:0]           alu_result0,
    input  logic [exec_pkg::xlen-1:0]           alu_result1,
    input  logic                                alu_result0_valid,
    input  logic                                alu_result1_valid,
    input  logic                                privileged_0,
    input  logic                                csr_ren_ex1,
    input  logic [exec_pkg::xlen-1:0]           mul_res_hh,
    input  logic [exec_pkg::xlen-1:0]           mul_res_hl,
    input  logic [exec_pkg::xlen-1:0]           mul_res_lh,
    input  logic [exec_pkg::xlen-1:0]           mul_res_ll,
    input  logic [exec_pkg::xlen-1:0]           mul_compensate,
    input  logic                                excp_flag_in,
    input  logic [exec_pkg::excp_code_w-1:0]    exception_in,
    input  logic [exec_pkg::xlen-1:0]           badv_in,
    input  logic [exec_pkg::excp_code_w-1:0]    d_exception,
    input  logic [exec_pkg::xlen-1:0]           d_badv,

    output logic [exec_pkg::xlen-1:0]           ex1_ex2_pc0,
    output logic [exec_pkg::xlen-1:0]           ex1_ex2_pc1,
    output logic [exec_pkg::xlen-1:0]           ex1_ex2_inst0,
    output logic [exec_pkg::xlen-1:0]           ex1_ex2_inst1,
    output logic [exec_pkg::uop_w-1:0]          ex1_ex2_uop0,
    output logic [exec_pkg::uop_w-1:0]          ex1_ex2_uop1,
    output logic [exec_pkg::xlen-1:0]           ex1_ex2_imm0,
    output logic [exec_pkg::xlen-1:0]           ex1_ex2_imm1,
    output logic [exec_pkg::reg_idx_w-1:0]      ex1_ex2_rj0,
    output logic [exec_pkg::reg_idx_w-1:0]      ex1_ex2_rj1,
    output logic [exec_pkg::reg_idx_w-1:0]      ex1_ex2_rk0,
    output logic [exec_pkg::reg_idx_w-1:0]      ex1_ex2_rk1,
    output logic [exec_pkg::reg_idx_w-1:0]      ex1_ex2_rd0,
    output logic [exec_pkg::reg_idx_w-1:0]      ex1_ex2_rd1,
    output logic [exec_pkg::xlen-1:0]           ex1_ex2_alu_result0,
    output logic [exec_pkg::xlen-1:0]           ex1_ex2_alu_result1,
    output logic                                ex1_ex2_alu_result0_valid,
    output logic                                ex1_ex2_alu_result1_valid,
    output logic                                ex1_ex2_privileged_0,
    output logic                                csr_ren_ex2,
    output logic [exec_pkg::xlen-1:0]           ex1_ex2_mul_res_hh,
    output logic [exec_pkg::xlen-1:0]           ex1_ex2_mul_res_hl,
    output logic [exec_pkg::xlen-1:0]           ex1_ex2_mul_res_lh,
    output logic [exec_pkg::xlen-1:0]           ex1_ex2_mul_res_ll,
    output logic [exec_pkg::xlen-1:0]           ex1_ex2_mul_compensate,
    output logic                                ex1_ex2_excp_flag,
    output logic [exec_pkg::excp_code_w-1:0]    ex1_ex2_exception,
    output logic [exec_pkg::xlen-1:0]           ex1_ex2_badv
);
    import exec_pkg::*;

    logic [ex1_ex2_bundle_w-1:0] bundle_d;
    logic [ex1_ex2_bundle_w-1:0] bundle_q;
    logic                        excp_flag_d;
    logic [excp_code_w-1:0]      exception_d;
    logic [xlen-1:0]             badv_d;
    logic                        load_bubble;

    assign ex1_allowin = ex2_allowin;

    // flush wins over accept, an empty EX1 slot becomes a bubble
    assign load_bubble = flush_in | (ex2_allowin & ~ex1_readygo);

    // earlier-stage exception has priority over the decode one
    assign excp_flag_d = excp_flag_in | d_exception[excp_valid_bit];
    assign exception_d = excp_flag_in ? exception_in : d_exception;
    assign badv_d = excp_flag_in ? badv_in : d_badv;

    assign bundle_d = {pc0, pc1, uop0, uop1, imm0, imm1, rj0, rj1, rk0, rk1, rd0, rd1,
                       alu_result0, alu_result1, alu_result0_valid, alu_result1_valid,
                       privileged_0, csr_ren_ex1,
                       mul_res_hh, mul_res_hl, mul_res_lh, mul_res_ll, mul_compensate,
                       excp_flag_d, exception_d, badv_d};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bundle_q <= '0;
            ex1_ex2_inst0 <= inst_nop;
            ex1_ex2_inst1 <= inst_nop;
        end else if (load_bubble) begin
            bundle_q <= '0;
            ex1_ex2_inst0 <= inst_nop;
            ex1_ex2_inst1 <= inst_nop;
        end else if (ex2_allowin) begin
            bundle_q <= bundle_d;
            ex1_ex2_inst0 <= inst0;
            ex1_ex2_inst1 <= inst1;
        end
    end

    assign {ex1_ex2_pc0, ex1_ex2_pc1, ex1_ex2_uop0, ex1_ex2_uop1,
            ex1_ex2_imm0, ex1_ex2_imm1, ex1_ex2_rj0, ex1_ex2_rj1,
            ex1_ex2_rk0, ex1_ex2_rk1, ex1_ex2_rd0, ex1_ex2_rd1,
            ex1_ex2_alu_result0, ex1_ex2_alu_result1,
            ex1_ex2_alu_result0_valid, ex1_ex2_alu_result1_valid,
            ex1_ex2_privileged_0, csr_ren_ex2,
            ex1_ex2_mul_res_hh, ex1_ex2_mul_res_hl, ex1_ex2_mul_res_lh,
            ex1_ex2_mul_res_ll, ex1_ex2_mul_compensate,
            ex1_ex2_excp_flag, ex1_ex2_exception, ex1_ex2_badv} = bundle_q;

endmodule

//--- verilog/ex2_mul_merge.sv
`timescale 1ns/10ps

module ex2_mul_merge (
    input  logic [exec_pkg::uop_w-1:0] uop0,
    input  logic [exec_pkg::uop_w-1:0] uop1,
    input  logic [exec_pkg::xlen-1:0]  data_0,
    input  logic [exec_pkg::xlen-1:0]  data_1,
    input  logic                       data_0_valid,
    input  logic                       data_1_valid,
    input  logic [exec_pkg::xlen-1:0]  res_hh,
    input  logic [exec_pkg::xlen-1:0]  res_hl,
    input  logic [exec_pkg::xlen-1:0]  res_lh,
    input  logic [exec_pkg::xlen-1:0]  res_ll,
    input  logic [exec_pkg::xlen-1:0]  compensate,
    output logic [exec_pkg::xlen-1:0]  res0,
    output logic                       res0_valid,
    output logic [exec_pkg::xlen-1:0]  res1,
    output logic                       res1_valid
);
    import exec_pkg::*;

    logic [2*xlen-1:0] product;
    uop_op_e           op0;

    assign op0 = uop_op_e'(uop0[3:0]);

    // cross terms sit 16 bits up
    assign product = {res_hh, res_ll}
                   + {16'b0, res_hl, 16'b0}
                   + {16'b0, res_lh, 16'b0};

    always_comb begin
        res0_valid = 1'b1;
        case (op0)
            op_mul_w:   res0 = product[xlen-1:0];
            op_mulh_wu: res0 = product[2*xlen-1:xlen];
            op_mulh_w:  res0 = product[2*xlen-1:xlen] - compensate;
            default: begin
                res0 = data_0;
                res0_valid = data_0_valid;
            end
        endcase
    end

    // lane 1 has no multiplier
    assign res1 = data_1;
    assign res1_valid = data_1_valid;

endmodule

//--- verilog/exec_pipe_top.sv
`timescale 1ns/10ps

module exec_pipe_top (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             flush_in,
    input  logic                             ex1_readygo,
    input  logic                             ex2_allowin,
    output logic                             ex1_allowin,

    input  logic [exec_pkg::xlen-1:0]        ex1_pc0,
    input  logic [exec_pkg::xlen-1:0]        ex1_pc1,
    input  logic [exec_pkg::xlen-1:0]        ex1_inst0,
    input  logic [exec_pkg::xlen-1:0]        ex1_inst1,
    input  logic [exec_pkg::uop_w-1:0]       ex1_uop0,
    input  logic [exec_pkg::uop_w-1:0]       ex1_uop1,
    input  logic [exec_pkg::xlen-1:0]        ex1_imm0,
    input  logic [exec_pkg::xlen-1:0]        ex1_imm1,
    input  logic [exec_pkg::reg_idx_w-1:0]   ex1_rj0,
    input  logic [exec_pkg::reg_idx_w-1:0]   ex1_rj1,
    input  logic [exec_pkg::reg_idx_w-1:0]   ex1_rk0,
    input  logic [exec_pkg::reg_idx_w-1:0]   ex1_rk1,
    input  logic [exec_pkg::reg_idx_w-1:0]   ex1_rd0,
    input  logic [exec_pkg::reg_idx_w-1:0]   ex1_rd1,
    input  logic [exec_pkg::xlen-1:0]        src_a0,
    input  logic [exec_pkg::xlen-1:0]        src_b0,
    input  logic [exec_pkg::xlen-1:0]        src_a1,
    input  logic [exec_pkg::xlen-1:0]        src_b1,
    input  logic                             privileged_0,
    input  logic                             csr_ren,
    input  logic                             excp_flag_in,
    input  logic [exec_pkg::excp_code_w-1:0] exception_in,
    input  logic [exec_pkg::xlen-1:0]        badv_in,
    input  logic [exec_pkg::excp_code_w-1:0] d_exception,
    input  logic [exec_pkg::xlen-1:0]        d_badv,

    output logic [exec_pkg::xlen-1:0]        pc0,
    output logic [exec_pkg::xlen-1:0]        pc1,
    output logic [exec_pkg::xlen-1:0]        inst0,
    output logic [exec_pkg::xlen-1:0]        inst1,
    output logic [exec_pkg::reg_idx_w-1:0]   rd0,
    output logic [exec_pkg::reg_idx_w-1:0]   rd1,
    output logic [exec_pkg::reg_idx_w-1:0]   rj0,
    output logic [exec_pkg::reg_idx_w-1:0]   rj1,
    output logic [exec_pkg::reg_idx_w-1:0]   rk0,
    output logic [exec_pkg::reg_idx_w-1:0]   rk1,
    output logic [exec_pkg::xlen-1:0]        imm0,
    output logic [exec_pkg::xlen-1:0]        imm1,
    output logic [exec_pkg::xlen-1:0]        res0,
    output logic                             res0_valid,
    output logic [exec_pkg::xlen-1:0]        res1,
    output logic                             res1_valid,
    output logic                             privileged,
    output logic                             csr_ren_ex2,
    output logic                             excp_flag,
    output logic [exec_pkg::excp_code_w-1:0] exception,
    output logic [exec_pkg::xlen-1:0]        badv
);
    import exec_pkg::*;

    // EX1 results
    logic [xlen-1:0]  alu_result0;
    logic [xlen-1:0]  alu_result1;
    logic             alu_result0_valid;
    logic             alu_result1_valid;
    logic [xlen-1:0]  mul_hh;
    logic [xlen-1:0]  mul_hl;
    logic [xlen-1:0]  mul_lh;
    logic [xlen-1:0]  mul_ll;
    logic [xlen-1:0]  mul_comp;

    // registered bundle feeding EX2
    logic [uop_w-1:0] ex2_uop0;
    logic [uop_w-1:0] ex2_uop1;
    logic [xlen-1:0]  ex2_data0;
    logic [xlen-1:0]  ex2_data1;
    logic             ex2_data0_valid;
    logic             ex2_data1_valid;
    logic [xlen-1:0]  ex2_hh;
    logic [xlen-1:0]  ex2_hl;
    logic [xlen-1:0]  ex2_lh;
    logic [xlen-1:0]  ex2_ll;
    logic [xlen-1:0]  ex2_comp;

    ex1_alu ex1_alu0_inst (
        .uop          (ex1_uop0),
        .src_a        (src_a0),
        .src_b        (src_b0),
        .imm          (ex1_imm0),
        .result       (alu_result0),
        .result_valid (alu_result0_valid)
    );

    ex1_alu ex1_alu1_inst (
        .uop          (ex1_uop1),
        .src_a        (src_a1),
        .src_b        (src_b1),
        .imm          (ex1_imm1),
        .result       (alu_result1),
        .result_valid (alu_result1_valid)
    );

    // multiplier only on lane 0
    ex1_mul_partial ex1_mul_partial_inst (
        .src_a      (src_a0),
        .src_b      (src_b0),
        .res_hh     (mul_hh),
        .res_hl     (mul_hl),
        .res_lh     (mul_lh),
        .res_ll     (mul_ll),
        .compensate (mul_comp)
    );

    ex1_ex2_reg ex1_ex2_reg_inst (
        .clk                       (clk),
        .arst_n                    (arst_n),
        .flush_in                  (flush_in),
        .ex1_readygo               (ex1_readygo),
        .ex2_allowin               (ex2_allowin),
        .ex1_allowin               (ex1_allowin),
        .pc0                       (ex1_pc0),
        .pc1                       (ex1_pc1),
        .inst0                     (ex1_inst0),
        .inst1                     (ex1_inst1),
        .uop0                      (ex1_uop0),
        .uop1                      (ex1_uop1),
        .imm0                      (ex1_imm0),
        .imm1                      (ex1_imm1),
        .rj0                       (ex1_rj0),
        .rj1                       (ex1_rj1),
        .rk0                       (ex1_rk0),
        .rk1                       (ex1_rk1),
        .rd0                       (ex1_rd0),
        .rd1                       (ex1_rd1),
        .alu_result0               (alu_result0),
        .alu_result1               (alu_result1),
        .alu_result0_valid         (alu_result0_valid),
        .alu_result1_valid         (alu_result1_valid),
        .privileged_0              (privileged_0),
        .csr_ren_ex1               (csr_ren),
        .mul_res_hh                (mul_hh),
        .mul_res_hl                (mul_hl),
        .mul_res_lh                (mul_lh),
        .mul_res_ll                (mul_ll),
        .mul_compensate            (mul_comp),
        .excp_flag_in              (excp_flag_in),
        .exception_in              (exception_in),
        .badv_in                   (badv_in),
        .d_exception               (d_exception),
        .d_badv                    (d_badv),
        .ex1_ex2_pc0               (pc0),
        .ex1_ex2_pc1               (pc1),
        .ex1_ex2_inst0             (inst0),
        .ex1_ex2_inst1             (inst1),
        .ex1_ex2_uop0              (ex2_uop0),
        .ex1_ex2_uop1              (ex2_uop1),
        .ex1_ex2_imm0              (imm0),
        .ex1_ex2_imm1              (imm1),
        .ex1_ex2_rj0               (rj0),
        .ex1_ex2_rj1               (rj1),
        .ex1_ex2_rk0               (rk0),
        .ex1_ex2_rk1               (rk1),
        .ex1_ex2_rd0               (rd0),
        .ex1_ex2_rd1               (rd1),
        .ex1_ex2_alu_result0       (ex2_data0),
        .ex1_ex2_alu_result1       (ex2_data1),
        .ex1_ex2_alu_result0_valid (ex2_data0_valid),
        .ex1_ex2_alu_result1_valid (ex2_data1_valid),
        .ex1_ex2_privileged_0      (privileged),
        .csr_ren_ex2               (csr_ren_ex2),
        .ex1_ex2_mul_res_hh        (ex2_hh),
        .ex1_ex2_mul_res_hl        (ex2_hl),
        .ex1_ex2_mul_res_lh        (ex2_lh),
        .ex1_ex2_mul_res_ll        (ex2_ll),
        .ex1_ex2_mul_compensate    (ex2_comp),
        .ex1_ex2_excp_flag         (excp_flag),
        .ex1_ex2_exception         (exception),
        .ex1_ex2_badv              (badv)
    );

    ex2_mul_merge ex2_mul_merge_inst (
        .uop0         (ex2_uop0),
        .uop1         (ex2_uop1),
        .data_0       (ex2_data0),
        .data_1       (ex2_data1),
        .data_0_valid (ex2_data0_valid),
        .data_1_valid (ex2_data1_valid),
        .res_hh       (ex2_hh),
        .res_hl       (ex2_hl),
        .res_lh       (ex2_lh),
        .res_ll       (ex2_ll),
        .compensate   (ex2_comp),
        .res0         (res0),
        .res0_valid   (res0_valid),
        .res1         (res1),
        .res1_valid   (res1_valid)
    );

endmodule
